// File: logic/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

`define EXEC_XLEN        32
`define EXEC_REG_ADDR_W  5
`define EXEC_LINK_INC    32'd4
`define EXEC_PIPE_DEPTH  3

// opcodes handled here
`define EXEC_OP_R        7'b0110011
`define EXEC_OP_I        7'b0010011
`define EXEC_OP_JAL      7'b1101111
`define EXEC_OP_JALR     7'b1100111
`define EXEC_OP_BRANCH   7'b1100011
`define EXEC_OP_LUI      7'b0110111
`define EXEC_OP_AUIPC    7'b0010111

// alu group funct3
`define EXEC_F3_ADD      3'b000
`define EXEC_F3_SLL      3'b001
`define EXEC_F3_SLT      3'b010
`define EXEC_F3_SLTU     3'b011
`define EXEC_F3_XOR      3'b100
`define EXEC_F3_SR       3'b101
`define EXEC_F3_OR       3'b110
`define EXEC_F3_AND      3'b111

// branch group funct3
`define EXEC_F3_BEQ      3'b000
`define EXEC_F3_BNE      3'b001
`define EXEC_F3_BLT      3'b100
`define EXEC_F3_BGE      3'b101
`define EXEC_F3_BLTU     3'b110
`define EXEC_F3_BGEU     3'b111

`endif

// File: logic/exec_pkg.sv
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS
    } alu_op_e;

    // auipc travels as an alu instruction
    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_ALU,
        KIND_LUI,
        KIND_JAL,
        KIND_JALR,
        KIND_BRANCH
    } exec_kind_e;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]       op1;
        logic [`EXEC_XLEN-1:0]       op2;
        logic [`EXEC_XLEN-1:0]       offset;
        logic [`EXEC_XLEN-1:0]       inst;
        logic [`EXEC_XLEN-1:0]       inst_addr;
        logic                        reg_wen;
        logic [`EXEC_REG_ADDR_W-1:0] reg_waddr;
        logic                        int_flag;
        logic [`EXEC_XLEN-1:0]       int_addr;
    } issue_t;

    typedef struct packed {
        exec_kind_e                  kind;
        alu_op_e                     alu_op;
        logic [`EXEC_XLEN-1:0]       alu_a;
        logic [`EXEC_XLEN-1:0]       alu_b;
        logic [2:0]                  br_funct3;
        logic [`EXEC_XLEN-1:0]       link_base;
        logic [`EXEC_XLEN-1:0]       br_target;
        logic                        reg_wen;
        logic [`EXEC_REG_ADDR_W-1:0] reg_waddr;
        logic                        int_flag;
        logic [`EXEC_XLEN-1:0]       int_addr;
    } decoded_t;

    typedef struct packed {
        exec_kind_e                  kind;
        logic [`EXEC_XLEN-1:0]       alu_res;
        logic [2:0]                  br_funct3;
        logic [`EXEC_XLEN-1:0]       link_base;
        logic [`EXEC_XLEN-1:0]       br_target;
        logic                        reg_wen;
        logic [`EXEC_REG_ADDR_W-1:0] reg_waddr;
        logic                        int_flag;
        logic [`EXEC_XLEN-1:0]       int_addr;
    } executed_t;

    typedef struct packed {
        logic                        wen;
        logic [`EXEC_REG_ADDR_W-1:0] waddr;
        logic [`EXEC_XLEN-1:0]       wdata;
    } wb_t;

endpackage

`default_nettype wire

// File: logic/exec_decode.sv
`default_nettype none

`include "exec_cfg.svh"

module exec_decode import exec_pkg::*; (
    input  wire      clk_i,
    input  wire      rst_n_i,
    input  wire      issue_t issue_i,
    output decoded_t dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    decoded_t   dec_d;

    // shared by r-type and the shift immediates
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            `EXEC_F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            `EXEC_F3_SLL:  op = ALU_SLL;
            `EXEC_F3_SLT:  op = ALU_SLT;
            `EXEC_F3_SLTU: op = ALU_SLTU;
            `EXEC_F3_XOR:  op = ALU_XOR;
            `EXEC_F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            `EXEC_F3_OR:   op = ALU_OR;
            default:       op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = issue_i.inst[6:0];
    assign funct3 = issue_i.inst[14:12];
    assign funct7 = issue_i.inst[31:25];

    always_comb begin
        dec_d.kind      = KIND_NONE;
        dec_d.alu_op    = ALU_ADD;
        dec_d.alu_a     = issue_i.op1;
        dec_d.alu_b     = issue_i.op2;
        dec_d.br_funct3 = funct3;
        dec_d.link_base = issue_i.op1;
        dec_d.br_target = issue_i.inst_addr + issue_i.offset;
        dec_d.reg_wen   = issue_i.reg_wen;
        dec_d.reg_waddr = issue_i.reg_waddr;
        dec_d.int_flag  = issue_i.int_flag;
        dec_d.int_addr  = issue_i.int_addr;

        case (opcode)
            `EXEC_OP_R: begin
                dec_d.kind   = KIND_ALU;
                dec_d.alu_op = arith_op(funct3, funct7[5]);
            end
            `EXEC_OP_I: begin
                // addi never subtracts, bit 30 is part of the immediate
                dec_d.kind   = KIND_ALU;
                dec_d.alu_op = (funct3 == `EXEC_F3_ADD) ? ALU_ADD : arith_op(funct3, funct7[5]);
            end
            `EXEC_OP_LUI: begin
                dec_d.kind   = KIND_LUI;
                dec_d.alu_op = ALU_PASS;
            end
            `EXEC_OP_AUIPC: begin
                dec_d.kind  = KIND_ALU;
                dec_d.alu_b = issue_i.offset;
            end
            `EXEC_OP_JAL: begin
                dec_d.kind  = KIND_JAL;
                dec_d.alu_b = issue_i.offset;
            end
            `EXEC_OP_JALR: begin
                dec_d.kind      = KIND_JALR;
                dec_d.alu_b     = issue_i.offset;
                dec_d.link_base = issue_i.op2;
            end
            `EXEC_OP_BRANCH: begin
                dec_d.kind    = KIND_BRANCH;
                dec_d.reg_wen = 1'b0;
                case (funct3)
                    `EXEC_F3_BEQ, `EXEC_F3_BNE:   dec_d.alu_op = ALU_SUB;
                    `EXEC_F3_BLT, `EXEC_F3_BGE:   dec_d.alu_op = ALU_SLT;
                    `EXEC_F3_BLTU, `EXEC_F3_BGEU: dec_d.alu_op = ALU_SLTU;
                    default:                      dec_d.kind   = KIND_NONE;
                endcase
            end
            default: begin
                dec_d.reg_wen = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        dec_o <= dec_d;
        if (!rst_n_i) begin
            dec_o.kind     <= KIND_NONE;
            dec_o.reg_wen  <= 1'b0;
            dec_o.int_flag <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_alu.sv
`default_nettype none

`include "exec_cfg.svh"

module exec_alu import exec_pkg::*; (
    input  wire       clk_i,
    input  wire       rst_n_i,
    input  wire       decoded_t dec_i,
    output executed_t exe_o
);

    logic [4:0]            shamt;
    logic                  lt_s;
    logic                  lt_u;
    logic [`EXEC_XLEN-1:0] res;

    assign shamt = dec_i.alu_b[4:0];
    assign lt_s  = $signed(dec_i.alu_a) < $signed(dec_i.alu_b);
    assign lt_u  = dec_i.alu_a < dec_i.alu_b;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:  res = dec_i.alu_a + dec_i.alu_b;
            ALU_SUB:  res = dec_i.alu_a - dec_i.alu_b;
            ALU_SLL:  res = dec_i.alu_a << shamt;
            ALU_SLT:  res = {{(`EXEC_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: res = {{(`EXEC_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  res = dec_i.alu_a ^ dec_i.alu_b;
            ALU_SRL:  res = dec_i.alu_a >> shamt;
            ALU_SRA:  res = $signed(dec_i.alu_a) >>> shamt;
            ALU_OR:   res = dec_i.alu_a | dec_i.alu_b;
            ALU_AND:  res = dec_i.alu_a & dec_i.alu_b;
            ALU_PASS: res = dec_i.alu_a;
            default:  res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        exe_o.kind      <= dec_i.kind;
        exe_o.alu_res   <= res;
        exe_o.br_funct3 <= dec_i.br_funct3;
        exe_o.link_base <= dec_i.link_base;
        exe_o.br_target <= dec_i.br_target;
        exe_o.reg_wen   <= dec_i.reg_wen;
        exe_o.reg_waddr <= dec_i.reg_waddr;
        exe_o.int_flag  <= dec_i.int_flag;
        exe_o.int_addr  <= dec_i.int_addr;
        if (!rst_n_i) begin
            exe_o.kind     <= KIND_NONE;
            exe_o.reg_wen  <= 1'b0;
            exe_o.int_flag <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_resolve.sv
`default_nettype none

`include "exec_cfg.svh"

module exec_resolve import exec_pkg::*; (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire  executed_t             exe_i,
    output wb_t                         wb_o,
    output logic                        jump_flag_o,
    output logic [`EXEC_XLEN-1:0]       jump_addr_o
);

    logic                  taken;
    wb_t                   wb_d;
    logic                  jump_flag_d;
    logic [`EXEC_XLEN-1:0] jump_addr_d;

    // sub result for the equality pair, compare bit otherwise
    always_comb begin
        case (exe_i.br_funct3)
            `EXEC_F3_BEQ:  taken = ~|exe_i.alu_res;
            `EXEC_F3_BNE:  taken = |exe_i.alu_res;
            `EXEC_F3_BLT:  taken = exe_i.alu_res[0];
            `EXEC_F3_BGE:  taken = ~exe_i.alu_res[0];
            `EXEC_F3_BLTU: taken = exe_i.alu_res[0];
            `EXEC_F3_BGEU: taken = ~exe_i.alu_res[0];
            default:       taken = 1'b0;
        endcase
    end

    always_comb begin
        wb_d.wen    = exe_i.reg_wen;
        wb_d.waddr  = exe_i.reg_waddr;
        wb_d.wdata  = exe_i.alu_res;
        jump_flag_d = 1'b0;
        jump_addr_d = '0;

        case (exe_i.kind)
            KIND_JAL: begin
                wb_d.wdata  = exe_i.link_base + `EXEC_LINK_INC;
                jump_flag_d = 1'b1;
                jump_addr_d = exe_i.alu_res;
            end
            KIND_JALR: begin
                wb_d.wdata  = exe_i.link_base + `EXEC_LINK_INC;
                jump_flag_d = 1'b1;
                jump_addr_d = {exe_i.alu_res[`EXEC_XLEN-1:1], 1'b0};
            end
            KIND_BRANCH: begin
                jump_flag_d = taken;
                jump_addr_d = taken ? exe_i.br_target : '0;
            end
            default: begin
            end
        endcase

        // pending interrupt wins over everything
        if (exe_i.int_flag) begin
            wb_d.wen    = 1'b0;
            jump_flag_d = 1'b1;
            jump_addr_d = exe_i.int_addr;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_o        <= wb_d;
        jump_flag_o <= jump_flag_d;
        jump_addr_o <= jump_addr_d;
        if (!rst_n_i) begin
            wb_o.wen    <= 1'b0;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`default_nettype none

`include "exec_cfg.svh"

module exec_unit import exec_pkg::*; (
    input  wire                         clk_i,
    input  wire                         rst_n_i,

    input  wire [`EXEC_XLEN-1:0]        op1_i,
    input  wire [`EXEC_XLEN-1:0]        op2_i,
    input  wire [`EXEC_XLEN-1:0]        offset_i,
    input  wire [`EXEC_XLEN-1:0]        inst_i,
    input  wire [`EXEC_XLEN-1:0]        inst_addr_i,
    input  wire                         reg_wen_i,
    input  wire [`EXEC_REG_ADDR_W-1:0]  reg_waddr_i,
    input  wire                         int_flag_i,
    input  wire [`EXEC_XLEN-1:0]        int_addr_i,

    output logic                        reg_wen_o,
    output logic [`EXEC_REG_ADDR_W-1:0] reg_waddr_o,
    output logic [`EXEC_XLEN-1:0]       reg_wdata_o,
    output logic                        jump_flag_o,
    output logic [`EXEC_XLEN-1:0]       jump_addr_o
);

    issue_t    issue;
    decoded_t  dec;
    executed_t exe;
    wb_t       wb;

    assign issue = '{op1: op1_i, op2: op2_i, offset: offset_i, inst: inst_i,
                     inst_addr: inst_addr_i, reg_wen: reg_wen_i,
                     reg_waddr: reg_waddr_i, int_flag: int_flag_i,
                     int_addr: int_addr_i};

    exec_decode u_decode (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .issue_i (issue),
        .dec_o   (dec)
    );

    exec_alu u_alu (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .dec_i   (dec),
        .exe_o   (exe)
    );

    exec_resolve u_resolve (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .exe_i       (exe),
        .wb_o        (wb),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o)
    );

    assign reg_wen_o   = wb.wen;
    assign reg_waddr_o = wb.waddr;
    assign reg_wdata_o = wb.wdata;

endmodule

`default_nettype wire

// File: bench/exec_checker.sv
`default_nettype none

`include "exec_cfg.svh"

module exec_checker import exec_pkg::*; #(
    parameter int NAME_W = 96
) (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire                         check_i,
    input  wire [NAME_W-1:0]            name_i,
    input  wire  wb_t                   exp_wb_i,
    input  wire                         exp_jump_flag_i,
    input  wire [`EXEC_XLEN-1:0]        exp_jump_addr_i,
    input  wire                         reg_wen_i,
    input  wire [`EXEC_REG_ADDR_W-1:0]  reg_waddr_i,
    input  wire [`EXEC_XLEN-1:0]        reg_wdata_i,
    input  wire                         jump_flag_i,
    input  wire [`EXEC_XLEN-1:0]        jump_addr_i,
    output int                          errors_o,
    output int                          checks_o
);

    typedef struct packed {
        logic                  valid;
        logic [NAME_W-1:0]     name;
        wb_t                   wb;
        logic                  jump_flag;
        logic [`EXEC_XLEN-1:0] jump_addr;
    } expect_t;

    expect_t exp_q [`EXEC_PIPE_DEPTH];
    expect_t due;
    int      errors = 0;
    int      checks = 0;

    assign due      = exp_q[`EXEC_PIPE_DEPTH-1];
    assign errors_o = errors;
    assign checks_o = checks;

    task automatic check_value(input logic [NAME_W-1:0] name, input logic [8*9-1:0] field,
                               input logic [`EXEC_XLEN-1:0] exp,
                               input logic [`EXEC_XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0s %0s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    // one slot per stage, so expectations line up with the dut outputs
    always_ff @(posedge clk_i) begin
        exp_q[0] <= '{valid: check_i, name: name_i, wb: exp_wb_i,
                      jump_flag: exp_jump_flag_i, jump_addr: exp_jump_addr_i};
        for (int i = 1; i < `EXEC_PIPE_DEPTH; i++) begin
            exp_q[i] <= exp_q[i-1];
        end
        if (!rst_n_i) begin
            for (int i = 0; i < `EXEC_PIPE_DEPTH; i++) begin
                exp_q[i].valid <= 1'b0;
            end
        end
    end

    // sampled mid-cycle, well away from the updating edge
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (due.valid) begin
                check_value(due.name, "wen", {31'b0, due.wb.wen}, {31'b0, reg_wen_i});
                if (due.wb.wen) begin
                    check_value(due.name, "waddr", {27'b0, due.wb.waddr}, {27'b0, reg_waddr_i});
                    check_value(due.name, "wdata", due.wb.wdata, reg_wdata_i);
                end
                check_value(due.name, "jump_flag", {31'b0, due.jump_flag}, {31'b0, jump_flag_i});
                if (due.jump_flag) begin
                    check_value(due.name, "jump_addr", due.jump_addr, jump_addr_i);
                end
            end else begin
                // nothing due yet, the outputs must stay quiet
                check_value("idle", "wen", 32'h0, {31'b0, reg_wen_i});
                check_value("idle", "jump_flag", 32'h0, {31'b0, jump_flag_i});
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/exec_unit_tb.sv
`default_nettype none

`include "exec_cfg.svh"

module exec_unit_tb import exec_pkg::*; ();

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY  = 2;
    localparam int NAME_W       = 8*12;

    // one issue address for every row and one branch offset
    localparam logic [`EXEC_XLEN-1:0] BR_ADDR   = 32'h0000_1000;
    localparam logic [`EXEC_XLEN-1:0] BR_OFF    = 32'h0000_0080;
    localparam logic [`EXEC_XLEN-1:0] BR_TARGET = 32'h0000_1080;

    typedef struct packed {
        logic [NAME_W-1:0]           name;
        logic [`EXEC_XLEN-1:0]       inst;
        logic [`EXEC_XLEN-1:0]       op1;
        logic [`EXEC_XLEN-1:0]       op2;
        logic [`EXEC_XLEN-1:0]       offset;
        logic                        reg_wen;
        logic [`EXEC_REG_ADDR_W-1:0] reg_waddr;
        logic                        int_flag;
        logic [`EXEC_XLEN-1:0]       int_addr;
        wb_t                         exp_wb;
        logic                        exp_jump_flag;
        logic [`EXEC_XLEN-1:0]       exp_jump_addr;
    } row_t;

    logic                        clk;
    logic                        rst_n;
    logic [`EXEC_XLEN-1:0]       op1;
    logic [`EXEC_XLEN-1:0]       op2;
    logic [`EXEC_XLEN-1:0]       offset;
    logic [`EXEC_XLEN-1:0]       inst;
    logic [`EXEC_XLEN-1:0]       inst_addr;
    logic                        reg_wen;
    logic [`EXEC_REG_ADDR_W-1:0] reg_waddr;
    logic                        int_flag;
    logic [`EXEC_XLEN-1:0]       int_addr;
    logic                        dut_wen;
    logic [`EXEC_REG_ADDR_W-1:0] dut_waddr;
    logic [`EXEC_XLEN-1:0]       dut_wdata;
    logic                        dut_jump_flag;
    logic [`EXEC_XLEN-1:0]       dut_jump_addr;
    logic                        check;
    logic [NAME_W-1:0]           exp_name;
    wb_t                         exp_wb;
    logic                        exp_jump_flag;
    logic [`EXEC_XLEN-1:0]       exp_jump_addr;
    int                          errors;
    int                          checks;
    row_t                        rows[$];
    bit                          table_ready = 1'b0;

    exec_unit u_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .op1_i       (op1),
        .op2_i       (op2),
        .offset_i    (offset),
        .inst_i      (inst),
        .inst_addr_i (inst_addr),
        .reg_wen_i   (reg_wen),
        .reg_waddr_i (reg_waddr),
        .int_flag_i  (int_flag),
        .int_addr_i  (int_addr),
        .reg_wen_o   (dut_wen),
        .reg_waddr_o (dut_waddr),
        .reg_wdata_o (dut_wdata),
        .jump_flag_o (dut_jump_flag),
        .jump_addr_o (dut_jump_addr)
    );

    exec_checker #(.NAME_W(NAME_W)) u_check (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .check_i         (check),
        .name_i          (exp_name),
        .exp_wb_i        (exp_wb),
        .exp_jump_flag_i (exp_jump_flag),
        .exp_jump_addr_i (exp_jump_addr),
        .reg_wen_i       (dut_wen),
        .reg_waddr_i     (dut_waddr),
        .reg_wdata_i     (dut_wdata),
        .jump_flag_i     (dut_jump_flag),
        .jump_addr_i     (dut_jump_addr),
        .errors_o        (errors),
        .checks_o        (checks)
    );

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 10'b0, f3, 5'b0, `EXEC_OP_R};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'b0, f3, 5'b0, `EXEC_OP_I};
    endfunction

    function automatic logic [31:0] op_word(input logic [6:0] opcode, input logic [2:0] f3);
        return {17'b0, f3, 5'b0, opcode};
    endfunction

    task automatic add_row(input logic [NAME_W-1:0] name, input logic [31:0] word,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] off,
                           input logic wen, input logic [4:0] waddr,
                           input logic irq, input logic [31:0] irq_addr,
                           input logic exp_wen, input logic [31:0] exp_wdata,
                           input logic exp_jf, input logic [31:0] exp_ja);
        row_t r;
        r.name          = name;
        r.inst          = word;
        r.op1           = a;
        r.op2           = b;
        r.offset        = off;
        r.reg_wen       = wen;
        r.reg_waddr     = waddr;
        r.int_flag      = irq;
        r.int_addr      = irq_addr;
        r.exp_wb        = '{wen: exp_wen, waddr: waddr, wdata: exp_wdata};
        r.exp_jump_flag = exp_jf;
        r.exp_jump_addr = exp_ja;
        rows.push_back(r);
    endtask

    task automatic alu_row(input logic [NAME_W-1:0] name, input logic [31:0] word,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [4:0] waddr, input logic [31:0] result);
        add_row(name, word, a, b, 32'h0, 1'b1, waddr, 1'b0, 32'h0, 1'b1, result, 1'b0, 32'h0);
    endtask

    // branches ask for a write that must never happen
    task automatic branch_row(input logic [NAME_W-1:0] name, input logic [2:0] f3,
                              input logic [31:0] a, input logic [31:0] b, input logic taken);
        add_row(name, op_word(`EXEC_OP_BRANCH, f3), a, b, BR_OFF, 1'b1, 5'd31, 1'b0, 32'h0,
                1'b0, 32'h0, taken, taken ? BR_TARGET : 32'h0);
    endtask

    task automatic build_table();
        alu_row("add",    r_word(7'h00, `EXEC_F3_ADD),  32'd5, 32'd7, 5'd1, 32'd12);
        alu_row("sub",    r_word(7'h20, `EXEC_F3_ADD),  32'd5, 32'd7, 5'd2, 32'hffff_fffe);
        alu_row("sll31",  r_word(7'h00, `EXEC_F3_SLL),  32'd1, 32'd31, 5'd3, 32'h8000_0000);
        alu_row("slt",    r_word(7'h00, `EXEC_F3_SLT),  32'hffff_ffff, 32'd1, 5'd4, 32'd1);
        alu_row("sltu",   r_word(7'h00, `EXEC_F3_SLTU), 32'hffff_ffff, 32'd1, 5'd5, 32'd0);
        alu_row("xor",    r_word(7'h00, `EXEC_F3_XOR),  32'hf0f0_f0f0, 32'hff00_ff00, 5'd6,
                32'h0ff0_0ff0);
        alu_row("srl",    r_word(7'h00, `EXEC_F3_SR),   32'h8000_0000, 32'd4, 5'd7, 32'h0800_0000);
        alu_row("sra",    r_word(7'h20, `EXEC_F3_SR),   32'h8000_0000, 32'd4, 5'd8, 32'hf800_0000);
        alu_row("or",     r_word(7'h00, `EXEC_F3_OR),   32'h0000_ffff, 32'h00ff_0000, 5'd9,
                32'h00ff_ffff);
        alu_row("and",    r_word(7'h00, `EXEC_F3_AND),  32'h0f0f_0f0f, 32'h00ff_ff00, 5'd10,
                32'h000f_0f00);
        alu_row("addi",   i_word(12'hfff, `EXEC_F3_ADD),  32'd10, 32'hffff_ffff, 5'd11, 32'd9);
        alu_row("slti",   i_word(12'hffe, `EXEC_F3_SLT),  32'hffff_fffd, 32'hffff_fffe, 5'd12, 32'd1);
        alu_row("sltiu",  i_word(12'hfff, `EXEC_F3_SLTU), 32'd1, 32'hffff_ffff, 5'd13, 32'd1);
        alu_row("xori",   i_word(12'h0ff, `EXEC_F3_XOR),  32'h0000_0f0f, 32'h0000_00ff, 5'd14,
                32'h0000_0ff0);
        alu_row("slli",   i_word(12'h004, `EXEC_F3_SLL),  32'd3, 32'd4, 5'd15, 32'h0000_0030);
        alu_row("srli",   i_word(12'h01f, `EXEC_F3_SR),   32'h8000_0000, 32'h1f, 5'd16, 32'd1);
        alu_row("srai",   i_word(12'h41f, `EXEC_F3_SR),   32'h8000_0000, 32'h41f, 5'd17,
                32'hffff_ffff);
        add_row("lui", op_word(`EXEC_OP_LUI, 3'b0), 32'h1234_5000, 32'h0000_dead, 32'h0,
                1'b1, 5'd18, 1'b0, 32'h0, 1'b1, 32'h1234_5000, 1'b0, 32'h0);
        add_row("auipc", op_word(`EXEC_OP_AUIPC, 3'b0), 32'h0000_1000, 32'h55, 32'h0002_0000,
                1'b1, 5'd19, 1'b0, 32'h0, 1'b1, 32'h0002_1000, 1'b0, 32'h0);
        add_row("jal", op_word(`EXEC_OP_JAL, 3'b0), 32'h100, 32'h0, 32'h40,
                1'b1, 5'd1, 1'b0, 32'h0, 1'b1, 32'h104, 1'b1, 32'h140);
        // target lands on an odd address, bit 0 must drop
        add_row("jalr", op_word(`EXEC_OP_JALR, 3'b0), 32'h200, 32'h300, 32'hb,
                1'b1, 5'd2, 1'b0, 32'h0, 1'b1, 32'h304, 1'b1, 32'h20a);
        branch_row("beq_taken",  `EXEC_F3_BEQ,  32'h55, 32'h55, 1'b1);
        branch_row("beq_not",    `EXEC_F3_BEQ,  32'h55, 32'h56, 1'b0);
        branch_row("bne_taken",  `EXEC_F3_BNE,  32'h55, 32'h56, 1'b1);
        branch_row("bne_not",    `EXEC_F3_BNE,  32'h55, 32'h55, 1'b0);
        branch_row("blt_taken",  `EXEC_F3_BLT,  32'hffff_ffff, 32'd1, 1'b1);
        branch_row("blt_not",    `EXEC_F3_BLT,  32'd1, 32'hffff_ffff, 1'b0);
        branch_row("bge_taken",  `EXEC_F3_BGE,  32'd1, 32'hffff_ffff, 1'b1);
        branch_row("bge_not",    `EXEC_F3_BGE,  32'hffff_ffff, 32'd1, 1'b0);
        branch_row("bltu_taken", `EXEC_F3_BLTU, 32'd1, 32'hffff_ffff, 1'b1);
        branch_row("bltu_not",   `EXEC_F3_BLTU, 32'hffff_ffff, 32'd1, 1'b0);
        branch_row("bgeu_taken", `EXEC_F3_BGEU, 32'hffff_ffff, 32'd1, 1'b1);
        branch_row("bgeu_not",   `EXEC_F3_BGEU, 32'd1, 32'hffff_ffff, 1'b0);
        add_row("irq", r_word(7'h00, `EXEC_F3_ADD), 32'd5, 32'd7, 32'h0,
                1'b1, 5'd19, 1'b1, 32'h800, 1'b0, 32'h0, 1'b1, 32'h800);
        alu_row("after_irq", r_word(7'h00, `EXEC_F3_ADD), 32'd3, 32'd4, 5'd20, 32'd7);
        add_row("bubble", 32'h0, 32'h11, 32'h22, 32'h0,
                1'b1, 5'd22, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0);
        add_row("unknown_op", op_word(7'b0000011, 3'b010), 32'h11, 32'h22, 32'h4,
                1'b1, 5'd23, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0);
        alu_row("add_again", r_word(7'h00, `EXEC_F3_ADD), 32'd100, 32'd23, 5'd21, 32'd123);
        for (int i = 0; i < `EXEC_PIPE_DEPTH; i++) begin
            add_row("flush", 32'h0, 32'h0, 32'h0, 32'h0,
                    1'b0, 5'd0, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0);
        end
    endtask

    task automatic drive_idle();
        inst          = 32'h0;
        op1           = 32'h0;
        op2           = 32'h0;
        offset        = 32'h0;
        inst_addr     = 32'h0;
        reg_wen       = 1'b0;
        reg_waddr     = '0;
        int_flag      = 1'b0;
        int_addr      = 32'h0;
        check         = 1'b0;
        exp_name      = '0;
        exp_wb        = '0;
        exp_jump_flag = 1'b0;
        exp_jump_addr = 32'h0;
    endtask

    // a live jal while in reset, only the reset keeps it off the outputs
    task automatic drive_reset_traffic();
        inst      = op_word(`EXEC_OP_JAL, 3'b0);
        op1       = 32'h100;
        offset    = 32'h40;
        reg_wen   = 1'b1;
        reg_waddr = 5'd1;
    endtask

    task automatic apply_row(input row_t r);
        inst          = r.inst;
        op1           = r.op1;
        op2           = r.op2;
        offset        = r.offset;
        inst_addr     = BR_ADDR;
        reg_wen       = r.reg_wen;
        reg_waddr     = r.reg_waddr;
        int_flag      = r.int_flag;
        int_addr      = r.int_addr;
        check         = 1'b1;
        exp_name      = r.name;
        exp_wb        = r.exp_wb;
        exp_jump_flag = r.exp_jump_flag;
        exp_jump_addr = r.exp_jump_addr;
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        drive_idle();
        drive_reset_traffic();
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;
        drive_idle();
        foreach (rows[i]) begin
            @(posedge clk);
            #DRIVE_DELAY apply_row(rows[i]);
        end
        @(posedge clk);
        #DRIVE_DELAY drive_idle();
        repeat (`EXEC_PIPE_DEPTH) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = (rows.size() + RESET_CYCLES + `EXEC_PIPE_DEPTH + 10) * PERIOD;
        #(limit);
        $display("timeout: the run did not finish within %0d time units", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: exec_unit.f
+incdir+logic
logic/exec_pkg.sv
logic/exec_decode.sv
logic/exec_alu.sv
logic/exec_resolve.sv
logic/exec_unit.sv
bench/exec_checker.sv
bench/exec_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the exec_unit testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f exec_unit.f --top-module exec_unit_tb \
    -Mdir obj_dir -o exec_unit_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/exec_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    echo "test failed, see $LOG"
    exit 1
fi

echo "test passed"
exit 0
